// File: project.f
+incdir+dv
design/hpFloatPkg.sv
design/fpAddPipePkg.sv
design/fpOperandUnpack.sv
design/fpAlignShift.sv
design/fpMantissaAdd.sv
design/fpNormalize.sv
design/fpRoundPack.sv
design/fpAddSubTop.sv
dv/clockGen.sv
dv/fpAddSubTb.sv

// File: Makefile
# Verilator build and run of the binary16 add/sub pipeline

VERILATOR ?= verilator
TOP ?= fpAddSubTb
FILELIST ?= project.f
BUILD_DIR ?= build
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "Result: PASSED" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/fpRefModel.svh
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// Binary16 word to real, subnormals read as zero
function automatic real halfToReal(input logic [15:0] h);
	real mag;
	int e;
	if (h[14:10] == 5'd0) begin
		return 0.0;
	end
	mag = 1.0 + h[9:0] / 1024.0; // Hidden one plus fraction
	e = int'(h[14:10]) - 15;
	while (e > 0) begin
		mag = mag * 2.0;
		e--;
	end
	while (e < 0) begin
		mag = mag / 2.0; // Exact in double
		e++;
	end
	return h[15] ? -mag : mag;
endfunction

// Expected {overflow, underflow, invalid, inexact, result} for a +/- b
function automatic logic [19:0] refAddSub(input logic [15:0] a, input logic [15:0] b,
	input logic sub);
	logic [15:0] bEff;
	logic nanIn;
	logic infA;
	logic infB;
	logic sgn;
	logic inexact;
	real sum;
	real mag;
	real scaled;
	real rem;
	int e;
	int q;
	bEff = b ^ {sub, 15'h0}; // Subtract as add of negated b
	infA = (a[14:10] == 5'h1F) && (a[9:0] == 10'h0);
	infB = (b[14:10] == 5'h1F) && (b[9:0] == 10'h0);
	nanIn = ((a[14:10] == 5'h1F) && (a[9:0] != 10'h0)) || ((b[14:10] == 5'h1F) && (b[9:0] != 10'h0));
	if (nanIn || (infA && infB && (a[15] != bEff[15]))) begin
		return {4'b0010, 1'b0, 5'h1F, 10'h200}; // Quiet NaN, invalid only
	end
	if (infA) begin
		return {4'b0000, a[15], 5'h1F, 10'h0};
	end
	if (infB) begin
		return {4'b0000, bEff[15], 5'h1F, 10'h0};
	end
	sum = halfToReal(a) + halfToReal(bEff); // Exact, well inside double precision
	if (sum == 0.0) begin
		return {4'b0000, a[15] & bEff[15], 15'h0}; // Only -0 + -0 stays negative
	end
	sgn = (sum < 0.0);
	mag = sgn ? -sum : sum;
	e = 0;
	while (mag >= 2.0) begin
		mag = mag / 2.0;
		e++;
	end
	while (mag < 1.0) begin
		mag = mag * 2.0;
		e--;
	end
	scaled = mag * 1024.0; // Integer part is the 11 bit significand
	q = $rtoi(scaled);
	rem = scaled - q;
	inexact = (rem != 0.0);
	if (rem > 0.5 || (rem == 0.5 && q[0])) begin
		q++; // Nearest, ties to even
	end
	if (q == 2048) begin
		q = 1024;
		e++;
	end
	if (e + 15 >= 31) begin
		return {4'b1001, sgn, 5'h1F, 10'h0};
	end
	if (e + 15 < 1) begin
		return {4'b0101, sgn, 15'h0}; // Below min normal
	end
	return {3'b000, inexact, sgn, 5'(e + 15), q[9:0]};
endfunction

`endif

// File: dv/fpAddSubTb.sv
`timescale 1ns/1ps

module fpAddSubTb;

	localparam int numTests = 6;
	localparam int opsRandom = 200;
	localparam int opsCancel = 60;
	localparam int opsRound = 80;
	localparam int opsRange = 60;
	localparam int opsSpecial = 40;
	localparam int opsEnable = 150;
	localparam int totalOps = opsRandom + opsCancel + opsRound + opsRange + opsSpecial
		+ opsEnable;
	localparam int cycleLimit = 2 * totalOps + 100; // Room for drains and en low stretches

	typedef struct packed {
		logic [31:0] stamp; // Enabled edge that sampled the op
		logic [15:0] result;
		logic [3:0] flags;
		logic [3:0] test;
	} expectItem_t;

	logic clk;
	logic rst;
	logic en;
	logic subtract;
	hpFloatPkg::halfWord_u opA;
	hpFloatPkg::halfWord_u opB;
	hpFloatPkg::halfWord_u result;
	fpAddPipePkg::excFlags_t flags;

	logic tagValid; // Inputs carry a tracked op
	logic [3:0] tagTest;
	logic cmpValid = 1'b0; // Compare due at next edge
	logic [15:0] cmpResult = 16'h0;
	logic [3:0] cmpFlags = 4'h0;
	logic [3:0] cmpTest = 4'h0;

	expectItem_t pending[$];
	int enCount = 0;
	int errors = 0;
	int cycles;
	int seed;
	int totalChecks;
	int checkCount [numTests];
	int failCount [numTests];

	`include "fpRefModel.svh"

	clockGen clkGen (
		.clk(clk),
		.rst(rst)
	);

	fpAddSubTop UUT (
		.clk(clk),
		.rst(rst),
		.en(en),
		.opA(opA),
		.opB(opB),
		.subtract(subtract),
		.result(result),
		.flags(flags)
	);

	function automatic string nameOf(input int test);
		case (test)
			0: return "randomAdd";
			1: return "cancel";
			2: return "rounding";
			3: return "range";
			4: return "special";
			default: return "enable";
		endcase
	endfunction

	function automatic int pickBetween(input int lo, input int hi);
		return lo + int'({$random(seed)} % (hi - lo + 1));
	endfunction

	function automatic logic [15:0] randomNormal();
		return {1'($random(seed)), 5'(pickBetween(1, 30)), 10'($random(seed))};
	endfunction

	function automatic logic [15:0] nanWord();
		return {1'($random(seed)), 5'h1F, 10'(pickBetween(1, 1023))}; // Any nonzero fraction
	endfunction

	task automatic issueOp(input logic [15:0] a, input logic [15:0] b, input logic sub,
		input int test);
		@(posedge clk);
		#1;
		en = 1'b1;
		opA.raw = a;
		opB.raw = b;
		subtract = sub;
		tagValid = 1'b1;
		tagTest = 4'(test);
	endtask

	// Untracked cycle with junk on the operands
	task automatic idleCycle(input logic enLevel);
		@(posedge clk);
		#1;
		en = enLevel;
		tagValid = 1'b0;
		opA.raw = 16'($random(seed));
		opB.raw = 16'($random(seed));
		subtract = 1'($random(seed));
	endtask

	task automatic drainAndReport(input int test);
		idleCycle(1'b1); // Last op gets sampled
		while (pending.size() > 0) begin
			idleCycle(1'b1);
		end
		idleCycle(1'b1); // Final compare reaches the assertions
		idleCycle(1'b1);
		$display("Test %0s finished: %0d checks, %0d failures", nameOf(test),
			checkCount[test], failCount[test]);
	endtask

	task automatic randomAdds();
		for (int i = 0; i < opsRandom; i++) begin
			issueOp(randomNormal(), randomNormal(), 1'b0, 0); // Mixed signs
		end
		drainAndReport(0);
	endtask

	task automatic cancelSweep();
		logic [15:0] a;
		for (int i = 0; i < opsCancel; i++) begin
			a = randomNormal();
			case (i % 3)
				0: issueOp(a, a, 1'b1, 1); // x - x
				1: issueOp(a, a ^ 16'h8000, 1'b0, 1); // x + -x
				default: issueOp(a, a ^ 16'(pickBetween(1, 31)), 1'b1, 1); // Long left shift
			endcase
		end
		drainAndReport(1);
	endtask

	task automatic roundingCases();
		logic [15:0] a;
		logic [15:0] b;
		int gap;
		for (int i = 0; i < opsRound; i++) begin
			a = randomNormal();
			if (i % 2 == 0) begin
				a[14:10] = 5'(pickBetween(12, 30));
				b = {1'($random(seed)), a[14:10] - 5'd11, 10'h0}; // Lone one on guard makes a tie
			end else begin
				gap = pickBetween(14, 25); // All of b goes to sticky
				a[14:10] = 5'(pickBetween(gap + 1, 30));
				b = randomNormal();
				b[14:10] = a[14:10] - 5'(gap);
			end
			issueOp(a, b, 1'($random(seed)), 2);
		end
		drainAndReport(2);
	endtask

	task automatic rangeCases();
		logic [15:0] a;
		logic [15:0] b;
		for (int i = 0; i < opsRange; i++) begin
			a = randomNormal();
			if (i % 2 == 0) begin
				b = randomNormal();
				a[14:10] = 5'(pickBetween(29, 30));
				b[14:10] = 5'(pickBetween(29, 30));
				b[15] = a[15]; // Same sign so magnitudes add
				issueOp(a, b, 1'b0, 3);
			end else begin
				a[14:10] = 5'(pickBetween(1, 2)); // Difference lands below min normal
				issueOp(a, a ^ 16'(pickBetween(1, 31)), 1'b1, 3);
			end
		end
		drainAndReport(3);
	endtask

	task automatic specialCases();
		logic [15:0] infWord;
		for (int i = 0; i < opsSpecial; i++) begin
			infWord = {1'($random(seed)), 5'h1F, 10'h0};
			case (pickBetween(0, 4))
				0: issueOp(nanWord(), randomNormal(), 1'($random(seed)), 4);
				1: issueOp(randomNormal(), nanWord(), 1'($random(seed)), 4);
				2: issueOp(infWord, infWord, 1'b1, 4); // inf - inf
				3: issueOp(infWord, randomNormal(), 1'($random(seed)), 4);
				default: issueOp(randomNormal(), {1'($random(seed)), 5'h0, 10'($random(seed))},
					1'($random(seed)), 4); // Subnormal flushed
			endcase
		end
		drainAndReport(4);
	endtask

	task automatic enableStretches();
		for (int i = 0; i < opsEnable; i++) begin
			if (pickBetween(0, 3) == 0) begin
				repeat (pickBetween(1, 3)) idleCycle(1'b0); // Pipeline frozen
			end
			issueOp(randomNormal(), randomNormal(), 1'($random(seed)), 5);
		end
		drainAndReport(5);
	endtask

	// Expected queue with one entry per tracked op popped on its fifth enabled edge
	always @(posedge clk) begin : scoreboard
		expectItem_t item;
		cmpValid <= 1'b0;
		if (!rst && en) begin
			enCount = enCount + 1;
			if (tagValid) begin
				item.stamp = 32'(enCount);
				{item.flags, item.result} = refAddSub(opA.raw, opB.raw, subtract);
				item.test = tagTest;
				pending.push_back(item);
			end
			if (pending.size() > 0 && pending[0].stamp + 4 == 32'(enCount)) begin
				item = pending.pop_front();
				cmpValid <= 1'b1;
				cmpResult <= item.result;
				cmpFlags <= item.flags;
				cmpTest <= item.test;
				checkCount[item.test]++;
			end
		end
	end

	resultMatch: assert property (@(posedge clk) cmpValid |-> result.raw == cmpResult)
		else begin
			$display("Fail %0s: expected result %h, actual %h", nameOf($sampled(cmpTest)),
				$sampled(cmpResult), $sampled(result.raw));
			failCount[$sampled(cmpTest)]++;
			errors++;
		end

	flagsMatch: assert property (@(posedge clk) cmpValid |-> flags == cmpFlags)
		else begin
			$display("Fail %0s: expected flags %b, actual %b", nameOf($sampled(cmpTest)),
				$sampled(cmpFlags), $sampled(flags));
			failCount[$sampled(cmpTest)]++;
			errors++;
		end

	// Frozen edge leaves outputs alone
	holdWhileIdle: assert property (@(posedge clk) disable iff (rst)
		!$past(en) |-> $stable(result.raw) && $stable(flags))
		else begin
			$display("Output changed on an edge where en was low");
			errors++;
		end

	// Nothing emerges before the fifth enabled edge
	clearAfterReset: assert property (@(posedge clk) disable iff (rst)
		enCount < 5 |-> result.raw == 16'h0 && flags == 4'h0)
		else begin
			$display("Output was not +0 with clear flags before the first result emerged");
			errors++;
		end

	initial begin
		cycles = 0;
		while (cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run went past %0d cycles without finishing", cycleLimit);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		en = 1'b0;
		subtract = 1'b0;
		opA.raw = 16'h0;
		opB.raw = 16'h0;
		tagValid = 1'b0;
		tagTest = 4'h0;
		seed = 32'h5c3f_0ffa;
		for (int t = 0; t < numTests; t++) begin
			checkCount[t] = 0;
			failCount[t] = 0;
		end
		@(posedge clk);
		while (rst) begin
			@(posedge clk);
		end
		randomAdds();
		cancelSweep();
		roundingCases();
		rangeCases();
		specialCases();
		enableStretches();
		totalChecks = 0;
		for (int t = 0; t < numTests; t++) begin
			totalChecks += checkCount[t];
		end
		$display("Summary: %0d tests, %0d checks, %0d errors", numTests, totalChecks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: dv/clockGen.sv
`timescale 1ns/1ps

module clockGen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// Reset held over the first two rising edges
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#1 rst = 1'b0; // Released off the edge like the other inputs
	end

endmodule

// File: design/fpAddSubTop.sv
`timescale 1ns/1ps

module fpAddSubTop (
	input logic clk,
	input logic rst,
	input logic en, // Advances all five stages
	input hpFloatPkg::halfWord_u opA,
	input hpFloatPkg::halfWord_u opB,
	input logic subtract, // 1 gives opA - opB
	output hpFloatPkg::halfWord_u result,
	output fpAddPipePkg::excFlags_t flags
);

	fpAddPipePkg::unpackStage_t unpackQ;
	fpAddPipePkg::alignStage_t alignQ;
	fpAddPipePkg::sumStage_t sumQ;
	fpAddPipePkg::normStage_t normQ;

	// Classify, order, exponent difference
	fpOperandUnpack unpackStage (
		.clk(clk),
		.rst(rst),
		.en(en),
		.opA(opA),
		.opB(opB),
		.subtract(subtract),
		.stageOut(unpackQ)
	);

	fpAlignShift alignStage (
		.clk(clk),
		.rst(rst),
		.en(en),
		.stageIn(unpackQ),
		.stageOut(alignQ)
	);

	fpMantissaAdd addStage (
		.clk(clk),
		.rst(rst),
		.en(en),
		.stageIn(alignQ),
		.stageOut(sumQ)
	);

	fpNormalize normStage (
		.clk(clk),
		.rst(rst),
		.en(en),
		.stageIn(sumQ),
		.stageOut(normQ)
	);

	// Final register drives result and flags
	fpRoundPack roundStage (
		.clk(clk),
		.rst(rst),
		.en(en),
		.stageIn(normQ),
		.result(result),
		.flags(flags)
	);

endmodule

// File: design/fpRoundPack.sv
`timescale 1ns/1ps

module fpRoundPack (
	input logic clk,
	input logic rst,
	input logic en,
	input fpAddPipePkg::normStage_t stageIn,
	output hpFloatPkg::halfWord_u result,
	output fpAddPipePkg::excFlags_t flags
);

	logic roundUp;
	logic [hpFloatPkg::sigWidth:0] sigRounded; // Extra bit for round carry
	logic sigCarry;
	logic signed [fpAddPipePkg::normExpWidth-1:0] expFinal;
	logic inexact;
	hpFloatPkg::halfWord_u resultNext;
	fpAddPipePkg::excFlags_t flagsNext;

	always_comb begin
		// Nearest even
		roundUp = stageIn.guard & (stageIn.round | stageIn.sticky | stageIn.sig[0]);
		sigRounded = {1'b0, stageIn.sig} + (hpFloatPkg::sigWidth+1)'(roundUp);
		sigCarry = sigRounded[hpFloatPkg::sigWidth]; // 1.111.. rounded to 10.000..
		expFinal = stageIn.exp + fpAddPipePkg::normExpWidth'(sigCarry);
		inexact = stageIn.guard | stageIn.round | stageIn.sticky;

		flagsNext = '0;
		resultNext.fields.sign = stageIn.sign;
		resultNext.fields.exp = expFinal[hpFloatPkg::expWidth-1:0];
		resultNext.fields.man = sigCarry ? sigRounded[hpFloatPkg::sigWidth-1:1]
			: sigRounded[hpFloatPkg::manWidth-1:0];

		if (stageIn.special == fpAddPipePkg::nan) begin
			resultNext.raw = hpFloatPkg::canonicalNaN;
			flagsNext.invalid = stageIn.invalid;
		end else if (stageIn.special == fpAddPipePkg::inf) begin
			resultNext.fields.sign = stageIn.specSign; // Exact infinity, no flag
			resultNext.fields.exp = '1;
			resultNext.fields.man = '0;
		end else if (stageIn.isZero) begin
			resultNext.fields.exp = '0; // Exact zero keeps its sign
			resultNext.fields.man = '0;
		end else if (expFinal >= hpFloatPkg::expMax) begin
			resultNext.fields.exp = '1; // Signed infinity
			resultNext.fields.man = '0;
			flagsNext.overflow = 1'b1;
			flagsNext.inexact = 1'b1;
		end else if (expFinal < 1) begin
			resultNext.fields.exp = '0; // Flush to signed zero
			resultNext.fields.man = '0;
			flagsNext.underflow = 1'b1;
			flagsNext.inexact = 1'b1;
		end else begin
			flagsNext.inexact = inexact;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0; // +0, flags clear
			flags <= '0;
		end else if (en) begin
			result <= resultNext;
			flags <= flagsNext;
		end
	end

	// Invalid only ever reports the quiet NaN
	nanOnInvalid: assert property (@(posedge clk) disable iff (rst)
		flags.invalid |-> result.raw == hpFloatPkg::canonicalNaN)
		else $error("Invalid flag without canonical NaN result");

	// Overflow result is a clean infinity
	infOnOverflow: assert property (@(posedge clk) disable iff (rst)
		flags.overflow |-> (&result.fields.exp) && (result.fields.man == '0))
		else $error("Overflow flag without infinity result");

endmodule

// File: design/fpNormalize.sv
`timescale 1ns/1ps

module fpNormalize (
	input logic clk,
	input logic rst,
	input logic en,
	input fpAddPipePkg::sumStage_t stageIn,
	output fpAddPipePkg::normStage_t stageOut
);

	logic carry; // Sum overflowed into bit 14
	logic [fpAddPipePkg::lzcWidth-1:0] lzc;
	logic [fpAddPipePkg::alignSpan-1:0] shifted;
	fpAddPipePkg::normStage_t stageNext;

	always_comb begin
		carry = stageIn.sum[fpAddPipePkg::extSigWidth-1];

		// Priority encoder where the highest one wins
		lzc = '0;
		for (int i = 0; i < fpAddPipePkg::alignSpan; i++) begin
			if (stageIn.sum[i]) begin
				lzc = fpAddPipePkg::lzcWidth'(fpAddPipePkg::alignSpan - 1 - i);
			end
		end
		shifted = stageIn.sum[fpAddPipePkg::alignSpan-1:0] << lzc;

		if (carry) begin
			// One step right with the lost bit in sticky
			stageNext.sig = stageIn.sum[fpAddPipePkg::extSigWidth-1 -: hpFloatPkg::sigWidth];
			stageNext.guard = stageIn.sum[3];
			stageNext.round = stageIn.sum[2];
			stageNext.sticky = stageIn.sum[1] | stageIn.sum[0];
			stageNext.exp = $signed({1'b0, stageIn.exp}) + 1;
		end else begin
			stageNext.sig = shifted[fpAddPipePkg::alignSpan-1 -: hpFloatPkg::sigWidth];
			stageNext.guard = shifted[2];
			stageNext.round = shifted[1];
			stageNext.sticky = shifted[0];
			stageNext.exp = $signed({1'b0, stageIn.exp})
				- $signed(fpAddPipePkg::normExpWidth'(lzc)); // May go to zero or below
		end

		stageNext.sign = stageIn.sign;
		stageNext.special = stageIn.special;
		stageNext.specSign = stageIn.specSign;
		stageNext.invalid = stageIn.invalid;
		stageNext.isZero = stageIn.isZero;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			stageOut <= '0;
			stageOut.isZero <= 1'b1; // Empty slot reads as +0
		end else if (en) begin
			stageOut <= stageNext;
		end
	end

endmodule

// File: design/fpMantissaAdd.sv
`timescale 1ns/1ps

module fpMantissaAdd (
	input logic clk,
	input logic rst,
	input logic en,
	input fpAddPipePkg::alignStage_t stageIn,
	output fpAddPipePkg::sumStage_t stageOut
);

	logic [fpAddPipePkg::extSigWidth-1:0] opLarge;
	logic [fpAddPipePkg::extSigWidth-1:0] opSmall;
	logic [fpAddPipePkg::extSigWidth-1:0] sum;
	fpAddPipePkg::sumStage_t stageNext;

	always_comb begin
		opLarge = {1'b0, stageIn.sigLarge, {fpAddPipePkg::grsWidth{1'b0}}};
		opSmall = {1'b0, stageIn.sigAligned}; // Carry slot empty
		sum = stageIn.effSub ? (opLarge - opSmall) : (opLarge + opSmall); // Larger first so no borrow

		stageNext.isZero = (sum == '0);
		// Cancellation gives +0 while -0 + -0 stays negative
		stageNext.sign = stageNext.isZero ? (stageIn.sign & ~stageIn.effSub) : stageIn.sign;
		stageNext.exp = stageIn.exp;
		stageNext.sum = sum;
		stageNext.special = stageIn.special;
		stageNext.specSign = stageIn.specSign;
		stageNext.invalid = stageIn.invalid;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			stageOut <= '0;
			stageOut.isZero <= 1'b1; // Empty slot reads as +0
		end else if (en) begin
			stageOut <= stageNext;
		end
	end

endmodule

// File: design/fpAlignShift.sv
`timescale 1ns/1ps

module fpAlignShift (
	input logic clk,
	input logic rst,
	input logic en,
	input fpAddPipePkg::unpackStage_t stageIn,
	output fpAddPipePkg::alignStage_t stageOut
);

	logic [fpAddPipePkg::alignSpan-1:0] ext; // Small significand with empty GRS
	logic [fpAddPipePkg::alignSpan-1:0] lvl1; // After coarse shift
	logic [fpAddPipePkg::alignSpan-1:0] lvl2; // After fine shift
	logic [fpAddPipePkg::alignSpan-1:0] mask1;
	logic [fpAddPipePkg::alignSpan-1:0] mask2;
	logic [fpAddPipePkg::lzcWidth-1:0] coarse;
	logic lost1;
	logic lost2;
	fpAddPipePkg::alignStage_t stageNext;

	always_comb begin
		ext = {stageIn.sigSmall, {fpAddPipePkg::grsWidth{1'b0}}};

		// Coarse step of 0, 4, 8 or 12
		coarse = {stageIn.expDiff[3:2], 2'b00};
		mask1 = '1 << coarse;
		lvl1 = ext >> coarse;
		lost1 = |(ext & ~mask1); // Bits falling off the end

		// Fine step of 0 to 3
		mask2 = '1 << stageIn.expDiff[1:0];
		lvl2 = lvl1 >> stageIn.expDiff[1:0];
		lost2 = |(lvl1 & ~mask2);

		stageNext.sign = stageIn.sign;
		stageNext.effSub = stageIn.effSub;
		stageNext.exp = stageIn.exp;
		stageNext.sigLarge = stageIn.sigLarge;
		stageNext.special = stageIn.special;
		stageNext.specSign = stageIn.specSign;
		stageNext.invalid = stageIn.invalid;

		if (stageIn.expDiff >= fpAddPipePkg::alignSpan) begin
			stageNext.sigAligned = {{(fpAddPipePkg::alignSpan-1){1'b0}}, |ext}; // All sticky
		end else begin
			stageNext.sigAligned = {lvl2[fpAddPipePkg::alignSpan-1:1], lvl2[0] | lost1 | lost2};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			stageOut <= '0;
		end else if (en) begin
			stageOut <= stageNext;
		end
	end

	// A far smaller operand must still leave a trace
	stickyKept: assert property (@(posedge clk) disable iff (rst)
		(en && stageIn.expDiff >= fpAddPipePkg::alignSpan && stageIn.sigSmall != '0)
		|=> stageOut.sigAligned[0])
		else $error("Sticky bit lost on a long alignment shift");

endmodule

// File: design/fpOperandUnpack.sv
`timescale 1ns/1ps

module fpOperandUnpack (
	input logic clk,
	input logic rst,
	input logic en,
	input hpFloatPkg::halfWord_u opA,
	input hpFloatPkg::halfWord_u opB,
	input logic subtract,
	output fpAddPipePkg::unpackStage_t stageOut
);

	logic signA;
	logic signB; // After subtract applied
	logic zeroA;
	logic zeroB; // Zero or subnormal input
	logic infA;
	logic infB;
	logic nanA;
	logic nanB;
	logic effSub;
	logic aLarger;
	logic [hpFloatPkg::expWidth+hpFloatPkg::manWidth-1:0] magA;
	logic [hpFloatPkg::expWidth+hpFloatPkg::manWidth-1:0] magB;
	logic [hpFloatPkg::sigWidth-1:0] sigA;
	logic [hpFloatPkg::sigWidth-1:0] sigB;
	logic [fpAddPipePkg::expWideWidth-1:0] expA;
	logic [fpAddPipePkg::expWideWidth-1:0] expB;
	fpAddPipePkg::unpackStage_t stageNext;

	always_comb begin
		signA = opA.fields.sign;
		signB = opB.fields.sign ^ subtract; // a - b as a + (-b)
		zeroA = (opA.fields.exp == '0); // Subnormals flushed
		zeroB = (opB.fields.exp == '0);
		nanA = (&opA.fields.exp) & (|opA.fields.man);
		nanB = (&opB.fields.exp) & (|opB.fields.man);
		infA = (&opA.fields.exp) & ~(|opA.fields.man);
		infB = (&opB.fields.exp) & ~(|opB.fields.man);

		// Flushed operands become true zeros
		expA = zeroA ? '0 : {1'b0, opA.fields.exp};
		expB = zeroB ? '0 : {1'b0, opB.fields.exp};
		sigA = zeroA ? '0 : {1'b1, opA.fields.man}; // Hidden one restored
		sigB = zeroB ? '0 : {1'b1, opB.fields.man};
		magA = zeroA ? '0 : {opA.fields.exp, opA.fields.man};
		magB = zeroB ? '0 : {opB.fields.exp, opB.fields.man};

		effSub = signA ^ signB;
		aLarger = (magA >= magB); // Exponent then fraction order

		stageNext.sign = aLarger ? signA : signB;
		stageNext.effSub = effSub;
		stageNext.exp = aLarger ? expA : expB;
		stageNext.sigLarge = aLarger ? sigA : sigB;
		stageNext.sigSmall = aLarger ? sigB : sigA;
		stageNext.expDiff = aLarger ? (expA - expB) : (expB - expA); // Never negative

		// NaN in, or inf - inf
		stageNext.invalid = nanA | nanB | (infA & infB & effSub);
		if (stageNext.invalid) begin
			stageNext.special = fpAddPipePkg::nan;
			stageNext.specSign = 1'b0;
		end else if (infA | infB) begin
			stageNext.special = fpAddPipePkg::inf;
			stageNext.specSign = infA ? signA : signB; // Same sign if both inf
		end else begin
			stageNext.special = fpAddPipePkg::none;
			stageNext.specSign = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			stageOut <= '0;
		end else if (en) begin
			stageOut <= stageNext;
		end
	end

endmodule

// File: design/fpAddPipePkg.sv
package fpAddPipePkg;

	localparam int grsWidth = 3; // Guard, round, sticky
	localparam int alignSpan = hpFloatPkg::sigWidth + grsWidth; // 14 bit aligned field
	localparam int extSigWidth = alignSpan + 1; // Plus carry bit
	localparam int expWideWidth = hpFloatPkg::expWidth + 1; // Exponent with headroom
	localparam int normExpWidth = hpFloatPkg::expWidth + 2; // Signed after normalization
	localparam int lzcWidth = $clog2(alignSpan);

	typedef enum logic [1:0] {
		none,
		inf,
		nan
	} specialCase_t;

	// Stage 1 to stage 2
	typedef struct packed {
		logic sign; // Sign of larger magnitude
		logic effSub; // Effective subtraction
		logic [expWideWidth-1:0] exp; // Larger exponent
		logic [hpFloatPkg::sigWidth-1:0] sigLarge;
		logic [hpFloatPkg::sigWidth-1:0] sigSmall;
		logic [expWideWidth-1:0] expDiff;
		specialCase_t special;
		logic specSign;
		logic invalid;
	} unpackStage_t;

	// Stage 2 to stage 3
	typedef struct packed {
		logic sign;
		logic effSub;
		logic [expWideWidth-1:0] exp;
		logic [hpFloatPkg::sigWidth-1:0] sigLarge;
		logic [alignSpan-1:0] sigAligned; // Smaller significand with GRS
		specialCase_t special;
		logic specSign;
		logic invalid;
	} alignStage_t;

	// Stage 3 to stage 4
	typedef struct packed {
		logic sign;
		logic [expWideWidth-1:0] exp;
		logic [extSigWidth-1:0] sum; // Carry, significand, GRS
		specialCase_t special;
		logic specSign;
		logic invalid;
		logic isZero; // Exact zero sum
	} sumStage_t;

	// Stage 4 to stage 5
	typedef struct packed {
		logic sign;
		logic signed [normExpWidth-1:0] exp; // May drop to zero or below
		logic [hpFloatPkg::sigWidth-1:0] sig; // Leading one at MSB
		logic guard;
		logic round;
		logic sticky;
		specialCase_t special;
		logic specSign;
		logic invalid;
		logic isZero;
	} normStage_t;

	typedef struct packed {
		logic overflow;
		logic underflow;
		logic invalid;
		logic inexact;
	} excFlags_t;

endpackage

// File: design/hpFloatPkg.sv
package hpFloatPkg;

	// IEEE binary16 layout
	localparam int expWidth = 5;
	localparam int manWidth = 10; // Stored fraction bits
	localparam int sigWidth = manWidth + 1; // Fraction plus hidden one
	localparam int expBias = 15;
	localparam int expMax = (1 << expWidth) - 1; // All-ones exponent of inf and NaN

	// Quiet NaN with sign clear and top fraction bit set
	localparam logic [15:0] canonicalNaN = 16'h7E00;

	typedef struct packed {
		logic sign;
		logic [expWidth-1:0] exp; // Biased exponent
		logic [manWidth-1:0] man; // Fraction without hidden one
	} halfFields_t;

	// One half word seen as raw bits or as fields
	typedef union packed {
		logic [15:0] raw;
		halfFields_t fields;
	} halfWord_u;

endpackage
